// ==== flist.f ====
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/sys_bus_pkg.sv
hdl/axi_lite_slave.sv
hdl/sys_bus_decoder.sv
hdl/hk_regs.sv
hdl/ramp_gen.sv
hdl/ps_bus_top.sv
testbench/tb_ps_bus_top.sv

// ==== hdl/axi_lite_pkg.sv ====
/*
 * Types for the AXI4-Lite side of the bridge.
 * Response codes and the bridge FSM states.
 */

package axi_lite_pkg;

  ////////////////////////////////////////////////////////////
  // AXI response codes
  ////////////////////////////////////////////////////////////

  // Only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  ////////////////////////////////////////////////////////////
  // Bridge FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    WR_BUS,
    WR_RESP,
    RD_BUS,
    RD_RESP
  } axi_state_e;

endpackage

// ==== hdl/axi_lite_slave.sv ====
/*
 * AXI4-Lite slave with one outstanding transaction.
 * Each write or read becomes one strobe on the system bus; the bus
 * acknowledge is returned to the host on B or R.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module axi_lite_slave (
  input  logic                    clk,
  input  logic                    rst_n,
  // Write address and data
  input  logic [`SYS_BUS_AW-1:0]  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`SYS_BUS_DW-1:0]  wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response
  output logic                    bvalid,
  input  logic                    bready,
  output axi_lite_pkg::axi_resp_e bresp,
  // Read address and data
  input  logic [`SYS_BUS_AW-1:0]  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic                    rvalid,
  input  logic                    rready,
  output axi_lite_pkg::axi_resp_e rresp,
  output logic [`SYS_BUS_DW-1:0]  rdata,
  // System bus master
  output logic [`SYS_BUS_AW-1:0]  sys_addr,
  output logic [`SYS_BUS_DW-1:0]  sys_wdata,
  output logic                    sys_wen,
  output logic                    sys_ren,
  input  logic [`SYS_BUS_DW-1:0]  sys_rdata,
  input  logic                    sys_err,
  input  logic                    sys_ack
);
  import axi_lite_pkg::*;

  axi_state_e state;
  axi_resp_e  resp_q;
  logic       wr_hs;
  logic       rd_hs;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  // Address only taken in IDLE, so a pending B or R blocks new ones
  // Write needs AW and W together and wins over a read
  assign wr_hs   = (state == IDLE) && awvalid && wvalid;
  assign rd_hs   = (state == IDLE) && arvalid && !wr_hs;

  assign awready = wr_hs;
  assign wready  = wr_hs;
  assign arready = rd_hs;

  // Responses held until the host takes them
  assign bvalid  = (state == WR_RESP);
  assign rvalid  = (state == RD_RESP);
  assign bresp   = resp_q;
  assign rresp   = resp_q;

  // wstrb not decoded
  // All registers behind the bus are whole words

  ////////////////////////////////////////////////////////////
  // FSM and bus strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sys_wen <= 1'b0;
      sys_ren <= 1'b0;
    end else begin
      // One cycle strobe right after the handshake
      sys_wen <= wr_hs;
      sys_ren <= rd_hs;
      case (state)
        IDLE: begin
          if (wr_hs) begin
            state <= WR_BUS;
          end else if (rd_hs) begin
            state <= RD_BUS;
          end
        end
        // Wait for decoder acknowledge
        WR_BUS:  if (sys_ack) state <= WR_RESP;
        WR_RESP: if (bready)  state <= IDLE;
        RD_BUS:  if (sys_ack) state <= RD_RESP;
        RD_RESP: if (rready)  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address, data and captured response
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      sys_addr  <= awaddr;
      sys_wdata <= wdata;
    end else if (rd_hs) begin
      sys_addr  <= araddr;
    end
    if (sys_ack && (state == WR_BUS || state == RD_BUS)) begin
      resp_q <= sys_err ? SLVERR : OKAY;
    end
    if (sys_ack && state == RD_BUS) begin
      rdata <= sys_rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(sys_wen && sys_ren));

  // B held with a stable response until bready
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== hdl/hk_regs.sv ====
/*
 * Housekeeping registers on the system bus.
 * ID, scratch word, LED outputs and ramp generator control.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module hk_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [7:0]             hk_addr,
  input  logic [`SYS_BUS_DW-1:0] hk_wdata,
  input  logic                   hk_wen,
  input  logic                   hk_ren,
  output logic [`SYS_BUS_DW-1:0] hk_rdata,
  output logic                   hk_ack,
  // Board side
  output logic [7:0]             led,
  output logic                   ramp_en,
  output logic [`DAC_W-1:0]      ramp_step,
  input  logic [`DAC_W-1:0]      dac_dat
);
  import sys_bus_pkg::*;

  hk_reg_e                reg_sel;
  logic [`SYS_BUS_DW-1:0] scratch;
  logic [`SYS_BUS_DW-1:0] rd_mux;

  assign reg_sel = hk_reg_e'(hk_addr);

  ////////////////////////////////////////////////////////////
  // Writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led       <= '0;
      ramp_en   <= 1'b0;
      ramp_step <= `DAC_W'(1);
      scratch   <= '0;
    end else if (hk_wen) begin
      case (reg_sel)
        HK_SCRATCH:   scratch   <= hk_wdata;
        HK_LED:       led       <= hk_wdata[7:0];
        HK_RAMP_CTL:  ramp_en   <= hk_wdata[0];
        HK_RAMP_STEP: ramp_step <= hk_wdata[`DAC_W-1:0];
        // ID read only, unknown offsets dropped
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Reads
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      HK_ID:        rd_mux = `HK_ID_VALUE;
      HK_SCRATCH:   rd_mux = scratch;
      HK_LED:       rd_mux[7:0] = led;
      HK_RAMP_CTL: begin
        // Live DAC code in the upper half
        rd_mux[16 +: `DAC_W] = dac_dat;
        rd_mux[0]            = ramp_en;
      end
      HK_RAMP_STEP: rd_mux[`DAC_W-1:0] = ramp_step;
      default:      rd_mux = '0;
    endcase
  end

  // Ack one cycle after any strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hk_ack <= 1'b0;
    end else begin
      hk_ack <= hk_wen | hk_ren;
    end
  end

  always_ff @(posedge clk) begin
    if (hk_ren) begin
      hk_rdata <= rd_mux;
    end
  end

  // One access at a time, never on top of the previous acknowledge
  a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
    (hk_wen || hk_ren) |-> !(hk_wen && hk_ren) && !hk_ack);

endmodule

// ==== hdl/ps_bus_top.sv ====
/*
 * Host bus subsystem top.
 * AXI4-Lite bridge, system bus decoder, housekeeping registers and ramp.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module ps_bus_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // AXI4-Lite from host
  input  logic [`SYS_BUS_AW-1:0]  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`SYS_BUS_DW-1:0]  wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_lite_pkg::axi_resp_e bresp,
  input  logic [`SYS_BUS_AW-1:0]  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic                    rvalid,
  input  logic                    rready,
  output axi_lite_pkg::axi_resp_e rresp,
  output logic [`SYS_BUS_DW-1:0]  rdata,
  // Board outputs
  output logic [7:0]              led,
  output logic [`DAC_W-1:0]       dac_dat
);

  // System bus
  logic [`SYS_BUS_AW-1:0] sys_addr;
  logic [`SYS_BUS_DW-1:0] sys_wdata;
  logic                   sys_wen;
  logic                   sys_ren;
  logic [`SYS_BUS_DW-1:0] sys_rdata;
  logic                   sys_err;
  logic                   sys_ack;

  // Housekeeping port
  logic [7:0]             hk_addr;
  logic [`SYS_BUS_DW-1:0] hk_wdata;
  logic                   hk_wen;
  logic                   hk_ren;
  logic [`SYS_BUS_DW-1:0] hk_rdata;
  logic                   hk_ack;

  // Ramp control
  logic                   ramp_en;
  logic [`DAC_W-1:0]      ramp_step;

  ////////////////////////////////////////////////////////////
  // Bridge and decode
  ////////////////////////////////////////////////////////////

  axi_lite_slave axi_slave0 (
    .clk       (clk      ),
    .rst_n     (rst_n    ),
    .awaddr    (awaddr   ),
    .awvalid   (awvalid  ),
    .awready   (awready  ),
    .wdata     (wdata    ),
    .wstrb     (wstrb    ),
    .wvalid    (wvalid   ),
    .wready    (wready   ),
    .bvalid    (bvalid   ),
    .bready    (bready   ),
    .bresp     (bresp    ),
    .araddr    (araddr   ),
    .arvalid   (arvalid  ),
    .arready   (arready  ),
    .rvalid    (rvalid   ),
    .rready    (rready   ),
    .rresp     (rresp    ),
    .rdata     (rdata    ),
    .sys_addr  (sys_addr ),
    .sys_wdata (sys_wdata),
    .sys_wen   (sys_wen  ),
    .sys_ren   (sys_ren  ),
    .sys_rdata (sys_rdata),
    .sys_err   (sys_err  ),
    .sys_ack   (sys_ack  )
  );

  sys_bus_decoder decoder0 (
    .clk       (clk      ),
    .rst_n     (rst_n    ),
    .sys_addr  (sys_addr ),
    .sys_wdata (sys_wdata),
    .sys_wen   (sys_wen  ),
    .sys_ren   (sys_ren  ),
    .sys_rdata (sys_rdata),
    .sys_err   (sys_err  ),
    .sys_ack   (sys_ack  ),
    .hk_addr   (hk_addr  ),
    .hk_wdata  (hk_wdata ),
    .hk_wen    (hk_wen   ),
    .hk_ren    (hk_ren   ),
    .hk_rdata  (hk_rdata ),
    .hk_ack    (hk_ack   )
  );

  ////////////////////////////////////////////////////////////
  // Housekeeping and ramp
  ////////////////////////////////////////////////////////////

  hk_regs hk0 (
    .clk       (clk      ),
    .rst_n     (rst_n    ),
    .hk_addr   (hk_addr  ),
    .hk_wdata  (hk_wdata ),
    .hk_wen    (hk_wen   ),
    .hk_ren    (hk_ren   ),
    .hk_rdata  (hk_rdata ),
    .hk_ack    (hk_ack   ),
    .led       (led      ),
    .ramp_en   (ramp_en  ),
    .ramp_step (ramp_step),
    .dac_dat   (dac_dat  )
  );

  ramp_gen ramp0 (
    .clk       (clk      ),
    .rst_n     (rst_n    ),
    .ramp_en   (ramp_en  ),
    .ramp_step (ramp_step),
    .dac_dat   (dac_dat  )
  );

endmodule

// ==== hdl/ramp_gen.sv ====
/*
 * Sawtooth source for the DAC.
 * Adds the step every clock while enabled, sits at zero otherwise.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module ramp_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ramp_en,
  input  logic [`DAC_W-1:0] ramp_step,
  output logic [`DAC_W-1:0] dac_dat
);

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_dat <= '0;
    end else if (ramp_en) begin
      // Wraps naturally at DAC_W bits
      dac_dat <= dac_dat + ramp_step;
    end else begin
      dac_dat <= '0;
    end
  end

endmodule

// ==== hdl/sys_bus_consts.svh ====
/*
 * Widths, region decode, register offsets and timing constants
 * shared by the AXI4-Lite bridge, the system bus decoder and housekeeping.
 */

`ifndef SYS_BUS_CONSTS_SVH
`define SYS_BUS_CONSTS_SVH

// Bus widths
`define SYS_BUS_AW 32
`define SYS_BUS_DW 32

// Region select field in the system bus address
`define SYS_REGION_MSB 23
`define SYS_REGION_LSB 20

// Housekeeping register map
`define HK_ID_VALUE      32'h7073_0001
`define HK_OFS_ID        8'h00
`define HK_OFS_SCRATCH   8'h04
`define HK_OFS_LED       8'h08
`define HK_OFS_RAMP_CTL  8'h0C
`define HK_OFS_RAMP_STEP 8'h10

// Cycles the decoder waits for a slave acknowledge
`define SYS_BUS_TIMEOUT 16

// Ramp generator DAC code width
`define DAC_W 14

`endif

// ==== hdl/sys_bus_decoder.sv ====
/*
 * System bus decoder.
 * Forwards accesses for the housekeeping region and answers unmapped
 * regions and missing acknowledges with an error.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module sys_bus_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  // From bridge
  input  logic [`SYS_BUS_AW-1:0] sys_addr,
  input  logic [`SYS_BUS_DW-1:0] sys_wdata,
  input  logic                   sys_wen,
  input  logic                   sys_ren,
  output logic [`SYS_BUS_DW-1:0] sys_rdata,
  output logic                   sys_err,
  output logic                   sys_ack,
  // Housekeeping slave
  output logic [7:0]             hk_addr,
  output logic [`SYS_BUS_DW-1:0] hk_wdata,
  output logic                   hk_wen,
  output logic                   hk_ren,
  input  logic [`SYS_BUS_DW-1:0] hk_rdata,
  input  logic                   hk_ack
);
  import sys_bus_pkg::*;

  localparam int CNT_W = $clog2(`SYS_BUS_TIMEOUT + 1);

  sys_region_e      region;
  logic             hk_sel;
  logic             strobe;
  logic             pend;
  logic             map_err;
  logic             tout;
  logic             ack_ok;
  logic [CNT_W-1:0] cnt;

  // Region decode
  assign region   = sys_region_e'(sys_addr[`SYS_REGION_MSB:`SYS_REGION_LSB]);
  assign hk_sel   = (region == REG_HK);
  assign strobe   = sys_wen | sys_ren;

  // Same cycle forwarding
  assign hk_addr  = sys_addr[7:0];
  assign hk_wdata = sys_wdata;
  assign hk_wen   = sys_wen & hk_sel;
  assign hk_ren   = sys_ren & hk_sel;

  // Only acks for an open access count
  assign ack_ok   = hk_ack & pend;
  // Last waiting cycle without ack
  assign tout     = pend & ~hk_ack & (cnt == CNT_W'(`SYS_BUS_TIMEOUT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend    <= 1'b0;
      cnt     <= '0;
      map_err <= 1'b0;
    end else begin
      // Unmapped gets its error one cycle later
      map_err <= strobe & ~hk_sel;
      if (strobe && hk_sel) begin
        pend <= 1'b1;
        cnt  <= '0;
      end else if (ack_ok || tout) begin
        pend <= 1'b0;
      end else if (pend) begin
        cnt  <= cnt + 1'b1;
      end
    end
  end

  assign sys_ack   = ack_ok | map_err | tout;
  assign sys_err   = map_err | tout;
  assign sys_rdata = ack_ok ? hk_rdata : '0;

  // Every strobe is answered, whatever the slave does
  a_ack_bound: assert property (@(posedge clk) disable iff (!rst_n)
    strobe |-> ##[1:`SYS_BUS_TIMEOUT+1] sys_ack);

endmodule

// ==== hdl/sys_bus_pkg.sv ====
/*
 * Types for the system bus side.
 * Region codes seen by the decoder and the housekeeping register names.
 */

`include "sys_bus_consts.svh"

package sys_bus_pkg;

  // Region field of the address
  // Any code other than REG_HK is unmapped
  typedef enum logic [`SYS_REGION_MSB-`SYS_REGION_LSB:0] {
    REG_HK = 0
  } sys_region_e;

  ////////////////////////////////////////////////////////////
  // Housekeeping register offsets
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    HK_ID        = `HK_OFS_ID,
    HK_SCRATCH   = `HK_OFS_SCRATCH,
    HK_LED       = `HK_OFS_LED,
    HK_RAMP_CTL  = `HK_OFS_RAMP_CTL,
    HK_RAMP_STEP = `HK_OFS_RAMP_STEP
  } hk_reg_e;

endpackage

// ==== testbench/tb_ps_bus_top.sv ====
/*
 * Testbench for the host bus subsystem.
 * An AXI4-Lite host model drives register traffic, and concurrent
 * assertions compare the results with a reference model in TB variables.
 */

`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module tb_ps_bus_top;
  import axi_lite_pkg::*;

  localparam int NUM_TXN = 35;
  localparam int CLK_NS  = 20;
  localparam logic [31:0] A_ID   = 32'h0000_0000 | `HK_OFS_ID;
  localparam logic [31:0] A_SCR  = 32'h0000_0000 | `HK_OFS_SCRATCH;
  localparam logic [31:0] A_LED  = 32'h0000_0000 | `HK_OFS_LED;
  localparam logic [31:0] A_CTL  = 32'h0000_0000 | `HK_OFS_RAMP_CTL;
  localparam logic [31:0] A_STEP = 32'h0000_0000 | `HK_OFS_RAMP_STEP;

  logic clk;
  logic rst_n;
  logic [31:0] awaddr;
  logic [31:0] wdata;
  logic [31:0] araddr;
  logic [3:0] wstrb;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic awready, wready, bvalid, arready, rvalid;
  axi_resp_e bresp, rresp;
  logic [31:0] rdata;
  logic [7:0] led;
  logic [`DAC_W-1:0] dac_dat;

  // Reference model and captured results
  logic [31:0] got_data, exp_data;
  axi_resp_e got_resp, exp_resp;
  logic [7:0] led_ref;
  logic [`DAC_W-1:0] step_ref;
  logic resp_chk, data_chk, led_chk, ramp_watch, dac_idle, post_rst;
  integer seed;

  ps_bus_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready), .rresp(rresp), .rdata(rdata),
    .led(led), .dac_dat(dac_dat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // Host model
  ////////////////////////////////////////////////////////////

  // Hold B or R for some cycles while offering new requests, then take it
  task automatic take_response(input int stall, input bit is_write);
    repeat (stall) begin
      @(posedge clk);
      #2;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      arvalid = 1'b1;
    end
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    if (is_write) bready = 1'b1;
    else rready = 1'b1;
    @(posedge clk);
    #2;
    bready = 1'b0;
    rready = 1'b0;
  endtask

  // Readies sampled on the falling edge, so the handshake edge is known
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input int stall);
    @(posedge clk);
    #2;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    got_resp = bresp;
    take_response(stall, 1'b1);
  endtask

  task automatic axi_read(input logic [31:0] addr, input int stall);
    @(posedge clk);
    #2;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    got_data = rdata;
    got_resp = rresp;
    take_response(stall, 1'b0);
  endtask

  // One cycle check pulse for the assertions below
  task automatic expect_result(input logic [31:0] d, input axi_resp_e r,
                               input bit with_data);
    @(posedge clk);
    #2;
    exp_data = d;
    exp_resp = r;
    resp_chk = 1'b1;
    data_chk = with_data;
    @(posedge clk);
    #2;
    resp_chk = 1'b0;
    data_chk = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////

  a_resp: assert property (@(posedge clk) disable iff (!rst_n)
    resp_chk |-> got_resp == exp_resp)
    else report_mismatch($sformatf("resp %0d, expected %0d", got_resp, exp_resp));

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    data_chk |-> got_data == exp_data)
    else report_mismatch($sformatf("rdata %h, expected %h", got_data, exp_data));

  a_led: assert property (@(posedge clk) disable iff (!rst_n)
    led_chk |-> led == led_ref)
    else report_mismatch($sformatf("led %h, expected %h", led, led_ref));

  // Ramp steps by the programmed amount, wrapping at DAC width
  a_ramp: assert property (@(posedge clk) disable iff (!rst_n)
    ramp_watch && $past(ramp_watch) |-> dac_dat == `DAC_W'($past(dac_dat) + step_ref))
    else report_mismatch($sformatf("dac_dat %0d, not one step of %0d on", dac_dat,
                                   step_ref));

  a_dac_idle: assert property (@(posedge clk) disable iff (!rst_n)
    dac_idle |-> dac_dat == '0)
    else report_mismatch("dac_dat not zero with ramp disabled");

  a_reset: assert property (@(posedge clk) disable iff (!rst_n)
    post_rst |-> led == '0 && dac_dat == '0 && !awready && !wready && !arready
                 && !bvalid && !rvalid)
    else report_mismatch("outputs not idle after reset");

  // Pending response blocks new addresses
  a_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid || rvalid |-> !awready && !wready && !arready)
    else report_mismatch("address accepted while a response was pending");

  // Host only raises a ready for a response it saw, so it must still be there
  a_b_wait: assert property (@(posedge clk) disable iff (!rst_n)
    bready |-> bvalid)
    else report_mismatch("bvalid dropped before bready");

  a_r_wait: assert property (@(posedge clk) disable iff (!rst_n)
    rready |-> rvalid)
    else report_mismatch("rvalid dropped before rready");

  // Response seen at the handshake equals the one first offered
  a_b_taken: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && bready |-> bresp == got_resp)
    else report_mismatch("bresp changed while waiting for bready");

  a_r_taken: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && rready |-> rdata == got_data && rresp == got_resp)
    else report_mismatch("read response changed while waiting for rready");

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    seed = 32'h8fac55b9;
    rst_n = 1'b0;
    {awaddr, wdata, araddr} = '0;
    wstrb = 4'hF;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    {resp_chk, data_chk, led_chk, ramp_watch, dac_idle, post_rst} = '0;
    got_data = '0;
    exp_data = '0;
    got_resp = OKAY;
    exp_resp = OKAY;
    led_ref  = '0;
    step_ref = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    post_rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    post_rst = 1'b0;

    // ID is fixed and read only
    axi_read(A_ID, 0);
    expect_result(`HK_ID_VALUE, OKAY, 1'b1);
    axi_write(A_ID, $random(seed), 0);
    expect_result('0, OKAY, 1'b0);
    axi_read(A_ID, 0);
    expect_result(`HK_ID_VALUE, OKAY, 1'b1);
    // Unknown offset in the HK region reads 0
    axi_read(32'h0000_0020, 0);
    expect_result('0, OKAY, 1'b1);

    repeat (8) begin
      v = $random(seed);
      axi_write(A_SCR, v, 0);
      expect_result('0, OKAY, 1'b0);
      axi_read(A_SCR, 0);
      expect_result(v, OKAY, 1'b1);
    end

    repeat (4) begin
      v = $random(seed);
      axi_write(A_LED, v, 0);
      led_ref = v[7:0];
      @(posedge clk);
      #2;
      led_chk = 1'b1;
      @(posedge clk);
      #2;
      led_chk = 1'b0;
    end

    // Unmapped regions
    axi_write(32'h0010_0000, $random(seed), 0);
    expect_result('0, SLVERR, 1'b0);
    axi_read(32'h00F0_0004, 0);
    expect_result('0, SLVERR, 1'b0);
    axi_write(32'h0080_0008, $random(seed), 0);
    expect_result('0, SLVERR, 1'b0);
    axi_read(32'h0030_0000, 0);
    expect_result('0, SLVERR, 1'b0);

    // Ramp with a random step
    v = $random(seed);
    step_ref = v[`DAC_W-1:0];
    axi_write(A_STEP, {18'h0, step_ref}, 0);
    axi_read(A_STEP, 0);
    expect_result({18'h0, step_ref}, OKAY, 1'b1);
    axi_write(A_CTL, 32'h1, 0);
    @(posedge clk);
    #2;
    ramp_watch = 1'b1;
    repeat (20) @(posedge clk);
    #2;
    ramp_watch = 1'b0;
    axi_write(A_CTL, 32'h0, 0);
    @(posedge clk);
    #2;
    dac_idle = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    dac_idle = 1'b0;

    // Back-pressure on B and R
    v = $random(seed);
    axi_write(A_SCR, v, 6);
    expect_result('0, OKAY, 1'b0);
    axi_read(A_SCR, 6);
    expect_result(v, OKAY, 1'b1);
    axi_read(32'h0040_0000, 5);
    expect_result('0, SLVERR, 1'b0);

    repeat (4) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog sized from the transaction count plus margin
  initial begin
    #((NUM_TXN * 40 + 500) * CLK_NS);
    $display("Watchdog expired, a handshake never completed");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule
